/* hw/mem_bus_pkg.sv */
package mem_bus_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned STRB_W = DATA_W / 8;

    // SRAM geometry
    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned IDX_W = $clog2(MEM_WORDS);
    // Byte offset bits below the word index
    localparam int unsigned WORD_LSB = $clog2(STRB_W);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Read address channel, len 0 is one beat and len 1 is two
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              len;
    } ar_req_t;

    // Write address channel
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } aw_req_t;

    // Write data channel
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_data_t;

    // Write response channel
    typedef struct packed {
        logic [1:0] resp;
    } b_resp_t;

    // Read data channel
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_data_t;

endpackage

/* hw/mem_arbiter.sv */
module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    // Fetch port
    input  mem_bus_pkg::ar_req_t  if_ar_i,
    input  logic                  if_ar_valid_i,
    output logic                  if_ar_ready_o,
    output mem_bus_pkg::r_data_t  if_r_o,
    output logic                  if_r_valid_o,
    input  logic                  if_r_ready_i,

    // Load/store port
    input  mem_bus_pkg::ar_req_t  ls_ar_i,
    input  logic                  ls_ar_valid_i,
    output logic                  ls_ar_ready_o,
    output mem_bus_pkg::r_data_t  ls_r_o,
    output logic                  ls_r_valid_o,
    input  logic                  ls_r_ready_i,
    input  mem_bus_pkg::aw_req_t  ls_aw_i,
    input  logic                  ls_aw_valid_i,
    output logic                  ls_aw_ready_o,
    input  mem_bus_pkg::w_data_t  ls_w_i,
    input  logic                  ls_w_valid_i,
    output logic                  ls_w_ready_o,
    output mem_bus_pkg::b_resp_t  ls_b_o,
    output logic                  ls_b_valid_o,
    input  logic                  ls_b_ready_i,

    // Memory side
    output mem_bus_pkg::ar_req_t  mem_ar_o,
    output logic                  mem_ar_valid_o,
    input  logic                  mem_ar_ready_i,
    input  mem_bus_pkg::r_data_t  mem_r_i,
    input  logic                  mem_r_valid_i,
    output logic                  mem_r_ready_o,
    output mem_bus_pkg::aw_req_t  mem_aw_o,
    output logic                  mem_aw_valid_o,
    input  logic                  mem_aw_ready_i,
    output mem_bus_pkg::w_data_t  mem_w_o,
    output logic                  mem_w_valid_o,
    input  logic                  mem_w_ready_i,
    input  mem_bus_pkg::b_resp_t  mem_b_i,
    input  logic                  mem_b_valid_i,
    output logic                  mem_b_ready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_LSU
    } rd_state_e;

    rd_state_e            state_q, state_d;
    // 0 grants fetch, 1 grants load/store
    logic                 grant_q, grant_d;
    logic                 beat_cnt_q;
    logic                 ar_sel_ls;
    logic                 ar_fire;
    logic                 r_fire;
    logic                 last_fire;
    mem_bus_pkg::ar_req_t ls_ar;

    // Load/store reads are always single beat
    always_comb begin
        ls_ar = ls_ar_i;
        ls_ar.len = 1'b0;
    end

    // Fetch wins in IDLE, otherwise the grant decides
    assign ar_sel_ls = (state_q == ST_IDLE) ? !if_ar_valid_i : grant_q;

    assign mem_ar_o       = ar_sel_ls ? ls_ar : if_ar_i;
    assign mem_ar_valid_o = ar_sel_ls ? ls_ar_valid_i : if_ar_valid_i;
    assign if_ar_ready_o  = !ar_sel_ls && mem_ar_ready_i;
    assign ls_ar_ready_o  = ar_sel_ls && mem_ar_ready_i;

    assign if_r_o        = mem_r_i;
    assign ls_r_o        = mem_r_i;
    assign if_r_valid_o  = !grant_q && mem_r_valid_i;
    assign ls_r_valid_o  = grant_q && mem_r_valid_i;
    assign mem_r_ready_o = grant_q ? ls_r_ready_i : if_r_ready_i;

    // Write path belongs to load/store
    assign mem_aw_o       = ls_aw_i;
    assign mem_aw_valid_o = ls_aw_valid_i;
    assign ls_aw_ready_o  = mem_aw_ready_i;
    assign mem_w_o        = ls_w_i;
    assign mem_w_valid_o  = ls_w_valid_i;
    assign ls_w_ready_o   = mem_w_ready_i;
    assign ls_b_o         = mem_b_i;
    assign ls_b_valid_o   = mem_b_valid_i;
    assign mem_b_ready_o  = ls_b_ready_i;

    assign ar_fire   = mem_ar_valid_o && mem_ar_ready_i;
    assign r_fire    = mem_r_valid_i && mem_r_ready_o;
    assign last_fire = r_fire && (beat_cnt_q == 1'b0);

    always_comb begin
        state_d = state_q;
        grant_d = grant_q;
        case (state_q)
            ST_IDLE: begin
                if (if_ar_valid_i) begin
                    state_d = ST_FETCH;
                    grant_d = 1'b0;
                end else if (ls_ar_valid_i) begin
                    state_d = ST_LSU;
                    grant_d = 1'b1;
                end
            end
            ST_FETCH: begin
                // Waiting load/store read goes straight after the burst
                if (last_fire) begin
                    state_d = ls_ar_valid_i ? ST_LSU : ST_IDLE;
                    grant_d = ls_ar_valid_i;
                end
            end
            ST_LSU: begin
                if (last_fire) begin
                    state_d = if_ar_valid_i ? ST_FETCH : ST_IDLE;
                    grant_d = 1'b0;
                end
            end
            default: begin
                state_d = ST_IDLE;
                grant_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            grant_q    <= 1'b0;
            beat_cnt_q <= 1'b0;
        end else begin
            state_q <= state_d;
            grant_q <= grant_d;
            // Beats left after the current one
            if (ar_fire) begin
                beat_cnt_q <= mem_ar_o.len;
            end else if (r_fire && beat_cnt_q != 1'b0) begin
                beat_cnt_q <= beat_cnt_q - 1'b1;
            end
        end
    end

endmodule

/* hw/sram_slave.sv */
module sram_slave (
    input  logic                  clk,
    input  logic                  rst,

    input  mem_bus_pkg::ar_req_t  ar_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output mem_bus_pkg::r_data_t  r_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,

    input  mem_bus_pkg::aw_req_t  aw_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  mem_bus_pkg::w_data_t  w_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output mem_bus_pkg::b_resp_t  b_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i
);

    logic [mem_bus_pkg::DATA_W-1:0] mem_q [mem_bus_pkg::MEM_WORDS];

    logic                           rd_valid_q;
    logic                           rd_left_q;
    logic [mem_bus_pkg::IDX_W-1:0]  rd_idx_q;
    logic [mem_bus_pkg::IDX_W-1:0]  rd_idx_next;
    logic [mem_bus_pkg::IDX_W-1:0]  ar_idx;
    logic [mem_bus_pkg::DATA_W-1:0] rd_data_q;
    logic                           ar_fire;
    logic                           r_fire;

    logic                           b_valid_q;
    logic                           wr_fire;
    logic [mem_bus_pkg::IDX_W-1:0]  wr_idx;

    // Read engine
    assign ar_ready_o  = !rd_valid_q;
    assign ar_fire     = ar_valid_i && ar_ready_o;
    assign r_fire      = rd_valid_q && r_ready_i;
    assign ar_idx      = ar_i.addr[mem_bus_pkg::WORD_LSB +: mem_bus_pkg::IDX_W];
    // Wraps at the end of the array
    assign rd_idx_next = rd_idx_q + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
            rd_left_q  <= 1'b0;
        end else if (ar_fire) begin
            rd_valid_q <= 1'b1;
            rd_left_q  <= ar_i.len;
        end else if (r_fire) begin
            if (rd_left_q) begin
                rd_left_q <= 1'b0;
            end else begin
                rd_valid_q <= 1'b0;
            end
        end
    end

    // Beat data is registered so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_idx_q  <= ar_idx;
            rd_data_q <= mem_q[ar_idx];
        end else if (r_fire && rd_left_q) begin
            rd_idx_q  <= rd_idx_next;
            rd_data_q <= mem_q[rd_idx_next];
        end
    end

    assign r_valid_o = rd_valid_q;
    assign r_o = '{
        data: rd_data_q,
        resp: mem_bus_pkg::RESP_OKAY,
        last: !rd_left_q
    };

    // Write engine, AW and W are taken together
    assign wr_fire    = aw_valid_i && w_valid_i && !b_valid_q;
    assign aw_ready_o = !b_valid_q && w_valid_i;
    assign w_ready_o  = !b_valid_q && aw_valid_i;
    assign wr_idx     = aw_i.addr[mem_bus_pkg::WORD_LSB +: mem_bus_pkg::IDX_W];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < mem_bus_pkg::STRB_W; i++) begin
                if (w_i.strb[i]) begin
                    mem_q[wr_idx][i*8 +: 8] <= w_i.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid_q <= 1'b0;
        end else if (wr_fire) begin
            b_valid_q <= 1'b1;
        end else if (b_valid_q && b_ready_i) begin
            b_valid_q <= 1'b0;
        end
    end

    assign b_valid_o = b_valid_q;
    assign b_o = '{resp: mem_bus_pkg::RESP_OKAY};

endmodule

/* hw/mem_subsys_top.sv */
module mem_subsys_top (
    input  logic                  clk,
    input  logic                  rst,

    // Fetch port
    input  mem_bus_pkg::ar_req_t  if_ar_i,
    input  logic                  if_ar_valid_i,
    output logic                  if_ar_ready_o,
    output mem_bus_pkg::r_data_t  if_r_o,
    output logic                  if_r_valid_o,
    input  logic                  if_r_ready_i,

    // Load/store port
    input  mem_bus_pkg::ar_req_t  ls_ar_i,
    input  logic                  ls_ar_valid_i,
    output logic                  ls_ar_ready_o,
    output mem_bus_pkg::r_data_t  ls_r_o,
    output logic                  ls_r_valid_o,
    input  logic                  ls_r_ready_i,
    input  mem_bus_pkg::aw_req_t  ls_aw_i,
    input  logic                  ls_aw_valid_i,
    output logic                  ls_aw_ready_o,
    input  mem_bus_pkg::w_data_t  ls_w_i,
    input  logic                  ls_w_valid_i,
    output logic                  ls_w_ready_o,
    output mem_bus_pkg::b_resp_t  ls_b_o,
    output logic                  ls_b_valid_o,
    input  logic                  ls_b_ready_i
);

    // Arbiter to SRAM
    mem_bus_pkg::ar_req_t mem_ar;
    logic                 mem_ar_valid;
    logic                 mem_ar_ready;
    mem_bus_pkg::r_data_t mem_r;
    logic                 mem_r_valid;
    logic                 mem_r_ready;
    mem_bus_pkg::aw_req_t mem_aw;
    logic                 mem_aw_valid;
    logic                 mem_aw_ready;
    mem_bus_pkg::w_data_t mem_w;
    logic                 mem_w_valid;
    logic                 mem_w_ready;
    mem_bus_pkg::b_resp_t mem_b;
    logic                 mem_b_valid;
    logic                 mem_b_ready;

    // Port names match the top level, only the memory side is listed
    mem_arbiter i_mem_arbiter (
        .*,
        .mem_ar_o       (mem_ar),
        .mem_ar_valid_o (mem_ar_valid),
        .mem_ar_ready_i (mem_ar_ready),
        .mem_r_i        (mem_r),
        .mem_r_valid_i  (mem_r_valid),
        .mem_r_ready_o  (mem_r_ready),
        .mem_aw_o       (mem_aw),
        .mem_aw_valid_o (mem_aw_valid),
        .mem_aw_ready_i (mem_aw_ready),
        .mem_w_o        (mem_w),
        .mem_w_valid_o  (mem_w_valid),
        .mem_w_ready_i  (mem_w_ready),
        .mem_b_i        (mem_b),
        .mem_b_valid_i  (mem_b_valid),
        .mem_b_ready_o  (mem_b_ready)
    );

    sram_slave i_sram_slave (
        .clk        (clk),
        .rst        (rst),
        .ar_i       (mem_ar),
        .ar_valid_i (mem_ar_valid),
        .ar_ready_o (mem_ar_ready),
        .r_o        (mem_r),
        .r_valid_o  (mem_r_valid),
        .r_ready_i  (mem_r_ready),
        .aw_i       (mem_aw),
        .aw_valid_i (mem_aw_valid),
        .aw_ready_o (mem_aw_ready),
        .w_i        (mem_w),
        .w_valid_i  (mem_w_valid),
        .w_ready_o  (mem_w_ready),
        .b_o        (mem_b),
        .b_valid_o  (mem_b_valid),
        .b_ready_i  (mem_b_ready)
    );

endmodule

/* tests/mem_subsys_assertions.sv */
module mem_subsys_assertions (
    input logic                 clk,
    input logic                 rst,
    input mem_bus_pkg::ar_req_t if_ar_i,
    input logic                 if_ar_valid_i,
    input logic                 if_ar_ready_i,
    input mem_bus_pkg::ar_req_t ls_ar_i,
    input logic                 ls_ar_valid_i,
    input logic                 ls_ar_ready_i,
    input logic                 if_r_valid_i,
    input logic                 ls_r_valid_i
);

    int unsigned fail_cnt = 0;
    // Port whose AR was accepted last, 1 for load/store
    logic owner_ls_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_ls_q <= 1'b0;
        end else if (if_ar_valid_i && if_ar_ready_i) begin
            owner_ls_q <= 1'b0;
        end else if (ls_ar_valid_i && ls_ar_ready_i) begin
            owner_ls_q <= 1'b1;
        end
    end

    if_ar_stable: assert property (@(posedge clk) disable iff (rst)
        if_ar_valid_i && !if_ar_ready_i |=> if_ar_valid_i && $stable(if_ar_i))
    else begin
        $error("Fetch AR dropped or changed before ready");
        fail_cnt++;
    end

    ls_ar_stable: assert property (@(posedge clk) disable iff (rst)
        ls_ar_valid_i && !ls_ar_ready_i |=> ls_ar_valid_i && $stable(ls_ar_i))
    else begin
        $error("Load/store AR dropped or changed before ready");
        fail_cnt++;
    end

    r_valid_onehot: assert property (@(posedge clk) disable iff (rst)
        !(if_r_valid_i && ls_r_valid_i))
    else begin
        $error("R valid high on both ports");
        fail_cnt++;
    end

    ar_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        !(if_ar_ready_i && ls_ar_ready_i))
    else begin
        $error("AR ready high on both ports");
        fail_cnt++;
    end

    r_to_owner: assert property (@(posedge clk) disable iff (rst)
        !((if_r_valid_i && owner_ls_q) || (ls_r_valid_i && !owner_ls_q)))
    else begin
        $error("R beat delivered to a port without a granted read");
        fail_cnt++;
    end

endmodule

bind mem_arbiter mem_subsys_assertions i_mem_subsys_assertions (
    .clk           (clk),
    .rst           (rst),
    .if_ar_i       (if_ar_i),
    .if_ar_valid_i (if_ar_valid_i),
    .if_ar_ready_i (if_ar_ready_o),
    .ls_ar_i       (ls_ar_i),
    .ls_ar_valid_i (ls_ar_valid_i),
    .ls_ar_ready_i (ls_ar_ready_o),
    .if_r_valid_i  (if_r_valid_o),
    .ls_r_valid_i  (ls_r_valid_o)
);

/* tests/tb_mem_subsys.sv */
module tb_mem_subsys;

    localparam int unsigned TIMEOUT = 200;

    logic                 clk;
    logic                 rst;
    mem_bus_pkg::ar_req_t if_ar;
    logic                 if_ar_valid;
    logic                 if_ar_ready;
    mem_bus_pkg::r_data_t if_r;
    logic                 if_r_valid;
    logic                 if_r_ready;
    mem_bus_pkg::ar_req_t ls_ar;
    logic                 ls_ar_valid;
    logic                 ls_ar_ready;
    mem_bus_pkg::r_data_t ls_r;
    logic                 ls_r_valid;
    logic                 ls_r_ready;
    mem_bus_pkg::aw_req_t ls_aw;
    logic                 ls_aw_valid;
    logic                 ls_aw_ready;
    mem_bus_pkg::w_data_t ls_w;
    logic                 ls_w_valid;
    logic                 ls_w_ready;
    mem_bus_pkg::b_resp_t ls_b;
    logic                 ls_b_valid;
    logic                 ls_b_ready;

    // Reference copy of the SRAM words
    logic [mem_bus_pkg::DATA_W-1:0] ref_mem [mem_bus_pkg::MEM_WORDS];
    // Global order of R transfers on both ports
    int unsigned beat_seq = 0;
    int unsigned ready_pct = 75;

    mem_subsys_top i_mem_subsys_top (
        .clk           (clk),
        .rst           (rst),
        .if_ar_i       (if_ar),
        .if_ar_valid_i (if_ar_valid),
        .if_ar_ready_o (if_ar_ready),
        .if_r_o        (if_r),
        .if_r_valid_o  (if_r_valid),
        .if_r_ready_i  (if_r_ready),
        .ls_ar_i       (ls_ar),
        .ls_ar_valid_i (ls_ar_valid),
        .ls_ar_ready_o (ls_ar_ready),
        .ls_r_o        (ls_r),
        .ls_r_valid_o  (ls_r_valid),
        .ls_r_ready_i  (ls_r_ready),
        .ls_aw_i       (ls_aw),
        .ls_aw_valid_i (ls_aw_valid),
        .ls_aw_ready_o (ls_aw_ready),
        .ls_w_i        (ls_w),
        .ls_w_valid_i  (ls_w_valid),
        .ls_w_ready_o  (ls_w_ready),
        .ls_b_o        (ls_b),
        .ls_b_valid_o  (ls_b_valid),
        .ls_b_ready_i  (ls_b_ready)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    always @(negedge clk) begin
        if (i_mem_subsys_top.i_mem_arbiter.i_mem_subsys_assertions.fail_cnt != 0) begin
            abort_run("A protocol assertion on the arbiter failed");
        end
    end

    // Bits 10:3 pick the word
    function automatic int unsigned word_index(input logic [31:0] addr);
        return addr[10:3];
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  strb);
        logic [63:0] result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic rand_ready();
        return $urandom_range(99) < ready_pct;
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb);
        int unsigned waited;
        @(negedge clk);
        ls_aw.addr  = addr;
        ls_w.data   = data;
        ls_w.strb   = strb;
        ls_aw_valid = 1'b1;
        ls_w_valid  = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!ls_aw_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("Timeout: load/store AW/W channel never accepted the write");
            end
            @(posedge clk);
        end
        check_value("write W ready with AW", 1, ls_w_ready);
        ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], data, strb);
        @(negedge clk);
        ls_aw_valid = 1'b0;
        ls_w_valid  = 1'b0;
        ls_b_ready  = rand_ready();
        waited = 0;
        @(posedge clk);
        while (!(ls_b_valid && ls_b_ready)) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("Timeout: load/store B channel never responded");
            end
            @(negedge clk);
            ls_b_ready = rand_ready();
            @(posedge clk);
        end
        check_value("write B response", mem_bus_pkg::RESP_OKAY, ls_b.resp);
        @(negedge clk);
        ls_b_ready = 1'b0;
    endtask

    task automatic read_burst(input bit is_ls, input logic [31:0] addr, input logic len,
                              output int unsigned first_seq, output int unsigned last_seq);
        int unsigned          waited;
        int unsigned          beat;
        int unsigned          nbeats;
        string                name;
        logic                 valid;
        logic                 ready;
        logic                 held;
        mem_bus_pkg::r_data_t beat_data;
        mem_bus_pkg::r_data_t held_data;
        logic [63:0]          expected;
        name = is_ls ? "load/store read" : "fetch read";
        // Load/store reads are one beat whatever len says
        nbeats = (is_ls || !len) ? 1 : 2;
        @(negedge clk);
        if (is_ls) begin
            ls_ar = '{addr: addr, len: len};
            ls_ar_valid = 1'b1;
        end else begin
            if_ar = '{addr: addr, len: len};
            if_ar_valid = 1'b1;
        end
        waited = 0;
        @(posedge clk);
        while (!(is_ls ? ls_ar_ready : if_ar_ready)) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run({"Timeout: AR channel stalled on ", name});
            end
            @(posedge clk);
        end
        @(negedge clk);
        if (is_ls) begin
            ls_ar_valid = 1'b0;
        end else begin
            if_ar_valid = 1'b0;
        end
        beat = 0;
        waited = 0;
        held = 1'b0;
        while (beat < nbeats) begin
            ready = rand_ready();
            if (is_ls) begin
                ls_r_ready = ready;
            end else begin
                if_r_ready = ready;
            end
            @(posedge clk);
            valid = is_ls ? ls_r_valid : if_r_valid;
            beat_data = is_ls ? ls_r : if_r;
            if (held) begin
                check_value({name, " valid held under back-pressure"}, 1, valid);
                check_value({name, " beat held under back-pressure"}, held_data, beat_data);
            end
            if (valid && ready) begin
                expected = ref_mem[(word_index(addr) + beat) % mem_bus_pkg::MEM_WORDS];
                check_value({name, " data"}, expected, beat_data.data);
                check_value({name, " resp"}, mem_bus_pkg::RESP_OKAY, beat_data.resp);
                check_value({name, " last"}, beat == nbeats - 1, beat_data.last);
                if (beat == 0) begin
                    first_seq = beat_seq;
                end
                last_seq = beat_seq;
                beat_seq++;
                beat++;
                waited = 0;
                held = 1'b0;
            end else begin
                held = valid;
                held_data = beat_data;
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run({"Timeout: R channel stalled on ", name});
                end
            end
            @(negedge clk);
        end
        if (is_ls) begin
            ls_r_ready = 1'b0;
        end else begin
            if_r_ready = 1'b0;
        end
        @(posedge clk);
        check_value({name, " extra beat"}, 0, is_ls ? ls_r_valid : if_r_valid);
    endtask

    initial begin
        int unsigned f_first;
        int unsigned f_last;
        int unsigned l_first;
        int unsigned l_last;
        logic [31:0] f_addr;
        logic [31:0] l_addr;
        logic        f_len;
        int unsigned f_delay;
        int unsigned l_delay;
        void'($urandom(15453));
        clk = 1'b0;
        rst = 1'b1;
        if_ar = '0;
        if_ar_valid = 1'b0;
        if_r_ready = 1'b0;
        ls_ar = '0;
        ls_ar_valid = 1'b0;
        ls_r_ready = 1'b0;
        ls_aw = '0;
        ls_aw_valid = 1'b0;
        ls_w = '0;
        ls_w_valid = 1'b0;
        ls_b_ready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check_value("reset R/B valid", 3'b000, {if_r_valid, ls_r_valid, ls_b_valid});

        // Fill every word with random byte offsets
        for (int i = 0; i < mem_bus_pkg::MEM_WORDS; i++) begin
            write_word((i << 3) | $urandom_range(7), {$urandom, $urandom}, 8'hFF);
        end

        for (int i = 0; i < 40; i++) begin
            f_addr = $urandom;
            write_word(f_addr, {$urandom, $urandom}, 8'($urandom_range(254, 1)));
            read_burst(1'b1, f_addr, 1'($urandom), l_first, l_last);
        end

        // Second beat of the last word wraps to word 0
        read_burst(1'b0, 32'h0000_07F8, 1'b1, f_first, f_last);
        for (int i = 0; i < 40; i++) begin
            read_burst(1'b0, $urandom, 1'($urandom), f_first, f_last);
        end

        for (int i = 0; i < 20; i++) begin
            f_addr = $urandom;
            l_addr = $urandom;
            f_len = 1'($urandom);
            fork
                read_burst(1'b0, f_addr, f_len, f_first, f_last);
                read_burst(1'b1, l_addr, 1'b0, l_first, l_last);
            join
            check_value("contention fetch before load/store", 1, f_last < l_first);
        end

        // Mostly stalled R ready with staggered requests
        ready_pct = 25;
        for (int i = 0; i < 30; i++) begin
            f_addr = $urandom;
            l_addr = $urandom;
            f_len = 1'($urandom);
            f_delay = $urandom_range(3);
            l_delay = $urandom_range(3);
            fork
                begin
                    repeat (f_delay) @(negedge clk);
                    read_burst(1'b0, f_addr, f_len, f_first, f_last);
                end
                begin
                    repeat (l_delay) @(negedge clk);
                    read_burst(1'b1, l_addr, 1'b0, l_first, l_last);
                end
            join
        end

        @(negedge clk);
        if (i_mem_subsys_top.i_mem_arbiter.i_mem_subsys_assertions.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
hw/mem_bus_pkg.sv
hw/mem_arbiter.sv
hw/sram_slave.sv
hw/mem_subsys_top.sv
tests/mem_subsys_assertions.sv
tests/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - hw/mem_bus_pkg.sv
      - hw/mem_arbiter.sv
      - hw/sram_slave.sv
      - hw/mem_subsys_top.sv
  - target: test
    files:
      - tests/mem_subsys_assertions.sv
      - tests/tb_mem_subsys.sv
